//--- hw/pcie_block_align_pkg.sv
package pcie_block_align_pkg;

  // lane geometry
  localparam int NUM_LANES   = 4;
  localparam int LANE_DATA_W = 32;
  localparam int LANE_K_W    = 4;

  // width of num_active_lanes_i
  localparam int LANE_CNT_W = 3;

  // 128b/130b block payload
  localparam int BLOCK_BITS = 128;

  // word counter width, holds up to 15 words per block
  localparam int WPB_W = 4;

  // PIPE width per rate
  localparam int PIPE_WIDTH_GEN1 = 8;
  localparam int PIPE_WIDTH_GEN2 = 16;
  localparam int PIPE_WIDTH_GEN3 = 16;
  localparam int PIPE_WIDTH_GEN4 = 32;
  localparam int PIPE_WIDTH_GEN5 = 32;

  typedef enum logic [2:0] {
    GEN1,
    GEN2,
    GEN3,
    GEN4,
    GEN5
  } rate_speed_e;

  // only two legal sync headers, anything else is misalignment
  typedef enum logic [1:0] {
    SYNC_DATA = 2'b01,
    SYNC_OS   = 2'b10
  } sync_header_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND_OS,
    ST_SEND_DATA
  } block_state_e;

  // one PIPE word on one lane
  typedef struct packed {
    logic [LANE_DATA_W-1:0] data;
    logic [LANE_K_W-1:0]    d_k;
    logic [1:0]             sync_header;
  } lane_word_t;

  // decoded link configuration, shared by all lanes
  typedef struct packed {
    logic                 block_mode;
    logic [WPB_W-1:0]     words_per_block;
    logic [NUM_LANES-1:0] lane_enable;
  } lane_cfg_t;

endpackage

//--- hw/rate_config.sv
`timescale 1ns/10ps

module rate_config (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  pcie_block_align_pkg::rate_speed_e             curr_data_rate_i,
  input  logic [pcie_block_align_pkg::LANE_CNT_W-1:0]   num_active_lanes_i,
  output pcie_block_align_pkg::lane_cfg_t               lane_cfg_o
);

  import pcie_block_align_pkg::*;

  localparam int WPB_MAX = (2 ** WPB_W) - 1;

  lane_cfg_t cfg_c;
  lane_cfg_t cfg_r;

  // map rate and lane count onto the per-lane configuration
  function automatic lane_cfg_t decode_cfg(rate_speed_e rate,
                                           logic [LANE_CNT_W-1:0] lanes);
    lane_cfg_t cfg;
    int        pipe_w;
    int        words;
    cfg    = '0;
    pipe_w = PIPE_WIDTH_GEN1;
    case (rate)
      GEN1: begin
        pipe_w = PIPE_WIDTH_GEN1;
      end
      GEN2: begin
        pipe_w = PIPE_WIDTH_GEN2;
      end
      GEN3: begin
        pipe_w         = PIPE_WIDTH_GEN3;
        cfg.block_mode = 1'b1;
      end
      GEN4: begin
        pipe_w         = PIPE_WIDTH_GEN4;
        cfg.block_mode = 1'b1;
      end
      GEN5: begin
        pipe_w         = PIPE_WIDTH_GEN5;
        cfg.block_mode = 1'b1;
      end
      // unknown encodings fall back to gen1
      default: begin
        pipe_w = PIPE_WIDTH_GEN1;
      end
    endcase
    words = BLOCK_BITS / pipe_w;
    // gen1 would need 16, saturate (block mode is off there)
    if (words > WPB_MAX) begin
      words = WPB_MAX;
    end
    cfg.words_per_block = WPB_W'(words);
    for (int i = 0; i < NUM_LANES; i++) begin
      cfg.lane_enable[i] = (i < int'(lanes));
    end
    return cfg;
  endfunction

  always_comb begin
    cfg_c = decode_cfg(curr_data_rate_i, num_active_lanes_i);
  end

  // one cycle from a config change to lane_cfg_o
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_r <= decode_cfg(GEN1, LANE_CNT_W'(NUM_LANES));
    end else begin
      cfg_r <= cfg_c;
    end
  end

  assign lane_cfg_o = cfg_r;

endmodule

//--- hw/lane_block_tracker.sv
`timescale 1ns/10ps

module lane_block_tracker #(
  // position of this lane, selects its lane_enable bit
  parameter int unsigned LANE = 0
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  pcie_block_align_pkg::lane_cfg_t  lane_cfg_i,
  input  logic                             link_up_i,
  input  pcie_block_align_pkg::lane_word_t word_i,
  input  logic                             valid_i,
  output pcie_block_align_pkg::lane_word_t os_word_o,
  output logic                             os_valid_o,
  output logic                             os_last_o,
  output pcie_block_align_pkg::lane_word_t data_word_o,
  output logic                             data_valid_o,
  output logic                             data_last_o
);

  import pcie_block_align_pkg::*;

  block_state_e     state_r;
  block_state_e     state_c;
  logic [WPB_W-1:0] count_r;
  logic [WPB_W-1:0] count_c;
  logic [WPB_W-1:0] count_inc;
  logic             accept;
  logic             block_done;

  logic             os_valid_c;
  logic             os_last_c;
  logic             data_valid_c;
  logic             data_last_c;

  logic             os_valid_r;
  logic             os_last_r;
  logic             data_valid_r;
  logic             data_last_r;
  lane_word_t       os_word_r;
  lane_word_t       data_word_r;

  // word is taken only on an enabled lane with the link up
  assign accept = valid_i && link_up_i && lane_cfg_i.lane_enable[LANE];

  // counter holds words already sent in the current block
  assign count_inc  = count_r + 1'b1;
  assign block_done = (count_inc == lane_cfg_i.words_per_block);

  always_comb begin
    state_c      = state_r;
    count_c      = count_r;
    os_valid_c   = 1'b0;
    os_last_c    = 1'b0;
    data_valid_c = 1'b0;
    data_last_c  = 1'b0;

    if (!link_up_i) begin
      // link loss throws away any partial block
      state_c = ST_IDLE;
      count_c = '0;
    end else if (!lane_cfg_i.block_mode) begin
      // 8b/10b rates, no blocks, everything is data
      state_c      = ST_IDLE;
      count_c      = '0;
      data_valid_c = accept;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (accept) begin
            if (word_i.sync_header == SYNC_OS) begin
              os_valid_c = 1'b1;
              count_c    = WPB_W'(1);
              state_c    = ST_SEND_OS;
            end else if (word_i.sync_header == SYNC_DATA) begin
              data_valid_c = 1'b1;
              count_c      = WPB_W'(1);
              state_c      = ST_SEND_DATA;
            end
            // other headers mean misalignment, word is dropped
          end
        end

        ST_SEND_OS: begin
          if (accept) begin
            os_valid_c = 1'b1;
            count_c    = count_inc;
            if (block_done) begin
              os_last_c = 1'b1;
              count_c   = '0;
              state_c   = ST_IDLE;
            end
          end
        end

        ST_SEND_DATA: begin
          if (accept) begin
            data_valid_c = 1'b1;
            count_c      = count_inc;
            if (block_done) begin
              data_last_c = 1'b1;
              count_c     = '0;
              state_c     = ST_IDLE;
            end
          end
        end

        default: begin
          state_c = ST_IDLE;
          count_c = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r      <= ST_IDLE;
      count_r      <= '0;
      os_valid_r   <= 1'b0;
      os_last_r    <= 1'b0;
      data_valid_r <= 1'b0;
      data_last_r  <= 1'b0;
    end else begin
      state_r      <= state_c;
      count_r      <= count_c;
      os_valid_r   <= os_valid_c;
      os_last_r    <= os_last_c;
      data_valid_r <= data_valid_c;
      data_last_r  <= data_last_c;
    end
  end

  // payload follows its path's valid, word passes unchanged
  always_ff @(posedge clk_i) begin
    if (os_valid_c) begin
      os_word_r <= word_i;
    end
    if (data_valid_c) begin
      data_word_r <= word_i;
    end
  end

  assign os_word_o    = os_word_r;
  assign os_valid_o   = os_valid_r;
  assign os_last_o    = os_last_r;
  assign data_word_o  = data_word_r;
  assign data_valid_o = data_valid_r;
  assign data_last_o  = data_last_r;

endmodule

//--- hw/block_alignment.sv
`timescale 1ns/10ps

module block_alignment (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          phy_link_up_i,
  input  pcie_block_align_pkg::rate_speed_e             curr_data_rate_i,
  input  logic [pcie_block_align_pkg::LANE_CNT_W-1:0]   num_active_lanes_i,

  // PIPE receive words, one per lane
  input  pcie_block_align_pkg::lane_word_t              data_i
                                                        [pcie_block_align_pkg::NUM_LANES],
  input  logic [pcie_block_align_pkg::NUM_LANES-1:0]    data_valid_i,

  // ordered-set path
  output pcie_block_align_pkg::lane_word_t              os_word_o
                                                        [pcie_block_align_pkg::NUM_LANES],
  output logic [pcie_block_align_pkg::NUM_LANES-1:0]    os_valid_o,
  output logic [pcie_block_align_pkg::NUM_LANES-1:0]    os_last_o,

  // TLP/DLLP data path
  output pcie_block_align_pkg::lane_word_t              data_word_o
                                                        [pcie_block_align_pkg::NUM_LANES],
  output logic [pcie_block_align_pkg::NUM_LANES-1:0]    data_valid_o,
  output logic [pcie_block_align_pkg::NUM_LANES-1:0]    data_last_o
);

  import pcie_block_align_pkg::*;

  // registered rate and lane decode, fanned out to every lane
  lane_cfg_t lane_cfg;

  rate_config u_rate_config (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .curr_data_rate_i   (curr_data_rate_i),
    .num_active_lanes_i (num_active_lanes_i),
    .lane_cfg_o         (lane_cfg)
  );

  // lanes are independent, each tracks its own block boundaries
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane
    lane_block_tracker #(
      .LANE (lane)
    ) u_lane_block_tracker (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .lane_cfg_i   (lane_cfg),
      .link_up_i    (phy_link_up_i),
      .word_i       (data_i[lane]),
      .valid_i      (data_valid_i[lane]),
      .os_word_o    (os_word_o[lane]),
      .os_valid_o   (os_valid_o[lane]),
      .os_last_o    (os_last_o[lane]),
      .data_word_o  (data_word_o[lane]),
      .data_valid_o (data_valid_o[lane]),
      .data_last_o  (data_last_o[lane])
    );
  end

endmodule

//--- testbench/block_alignment_sva.sv
`timescale 1ns/10ps

module block_alignment_sva (
  input logic                                       clk_i,
  input logic                                       rst_i,
  input logic                                       phy_link_up_i,
  input logic [pcie_block_align_pkg::NUM_LANES-1:0] os_valid_o,
  input logic [pcie_block_align_pkg::NUM_LANES-1:0] os_last_o,
  input logic [pcie_block_align_pkg::NUM_LANES-1:0] data_valid_o,
  input logic [pcie_block_align_pkg::NUM_LANES-1:0] data_last_o
);

  // a word takes exactly one path
  one_path_per_lane: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (os_valid_o & data_valid_o) == '0
  ) else $error("os and data valid high together on one lane");

  // last only ever marks a valid word
  last_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ((os_last_o & ~os_valid_o) | (data_last_o & ~data_valid_o)) == '0
  ) else $error("last asserted without its valid");

  // link loss clears both paths one cycle later
  link_down_quiet: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !phy_link_up_i |=> ((os_valid_o | data_valid_o) == '0)
  ) else $error("valid output high one cycle after link down");

endmodule

//--- testbench/block_alignment_tb.sv
`timescale 1ns/10ps

module block_alignment_tb;

  import pcie_block_align_pkg::*;

  localparam int NUM_TESTS    = 18;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_LIMIT  = 32;

  // one row of the stimulus table
  typedef struct packed {
    rate_speed_e            rate;
    logic [LANE_CNT_W-1:0]  lanes;
    logic                   link;
    logic [1:0]             lane;
    logic [1:0]             head_hdr;
    logic [1:0]             tail_hdr;
    logic [3:0]             words;
    logic [3:0]             exp_os;
    logic [3:0]             exp_data;
    logic [LANE_DATA_W-1:0] start;
  } stim_t;

  typedef struct packed {
    lane_word_t word;
    logic       last;
  } expect_t;

  logic                  clk_i;
  logic                  rst_i;
  logic                  phy_link_up_i;
  rate_speed_e           curr_data_rate_i;
  logic [LANE_CNT_W-1:0] num_active_lanes_i;
  lane_word_t            data_i [NUM_LANES];
  logic [NUM_LANES-1:0]  data_valid_i;
  lane_word_t            os_word_o [NUM_LANES];
  logic [NUM_LANES-1:0]  os_valid_o;
  logic [NUM_LANES-1:0]  os_last_o;
  lane_word_t            data_word_o [NUM_LANES];
  logic [NUM_LANES-1:0]  data_valid_o;
  logic [NUM_LANES-1:0]  data_last_o;

  stim_t        stim_table [NUM_TESTS];
  string        test_name [NUM_TESTS];
  string        cur_name;
  integer       seed;
  int           error_count;
  int           settle_cnt;
  int           os_seen;
  int           data_seen;

  // reference model with one block tracker per lane
  block_state_e model_state [NUM_LANES];
  int           model_count [NUM_LANES];
  expect_t      os_q [NUM_LANES][$];
  expect_t      data_q [NUM_LANES][$];

  block_alignment block_alignment_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .phy_link_up_i      (phy_link_up_i),
    .curr_data_rate_i   (curr_data_rate_i),
    .num_active_lanes_i (num_active_lanes_i),
    .data_i             (data_i),
    .data_valid_i       (data_valid_i),
    .os_word_o          (os_word_o),
    .os_valid_o         (os_valid_o),
    .os_last_o          (os_last_o),
    .data_word_o        (data_word_o),
    .data_valid_o       (data_valid_o),
    .data_last_o        (data_last_o)
  );

  bind block_alignment block_alignment_sva block_alignment_sva_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .phy_link_up_i (phy_link_up_i),
    .os_valid_o    (os_valid_o),
    .os_last_o     (os_last_o),
    .data_valid_o  (data_valid_o),
    .data_last_o   (data_last_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic halt_run();
    error_count++;
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_problem(input string msg);
    $display("Error: %s", msg);
    halt_run();
  endtask

  task automatic check_word(input string name, input lane_word_t exp, input lane_word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
      halt_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
      halt_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
      halt_run();
    end
  endtask

  // words per 128-bit block, 0 for the 8b/10b rates
  function automatic int block_words(input rate_speed_e rate);
    case (rate)
      GEN3:    return 8;
      GEN4:    return 4;
      GEN5:    return 4;
      default: return 0;
    endcase
  endfunction

  task automatic reset_model();
    for (int l = 0; l < NUM_LANES; l++) begin
      model_state[l] = ST_IDLE;
      model_count[l] = 0;
    end
  endtask

  task automatic predict_word(input stim_t s, input lane_word_t w);
    int      lane;
    int      wpb;
    expect_t e;
    lane   = int'(s.lane);
    wpb    = block_words(s.rate);
    e.word = w;
    e.last = 1'b0;
    // gated lanes and link down never reach an output
    if (s.link && lane < int'(s.lanes)) begin
      if (wpb == 0) begin
        data_q[lane].push_back(e);
      end else begin
        if (model_state[lane] == ST_IDLE) begin
          if (w.sync_header == SYNC_OS) begin
            model_state[lane] = ST_SEND_OS;
          end else if (w.sync_header == SYNC_DATA) begin
            model_state[lane] = ST_SEND_DATA;
          end
        end
        if (model_state[lane] != ST_IDLE) begin
          model_count[lane]++;
          e.last = (model_count[lane] == wpb);
          if (model_state[lane] == ST_SEND_OS) begin
            os_q[lane].push_back(e);
          end else begin
            data_q[lane].push_back(e);
          end
          if (e.last) begin
            model_state[lane] = ST_IDLE;
            model_count[lane] = 0;
          end
        end
      end
    end
  endtask

  function automatic bit queues_empty();
    for (int l = 0; l < NUM_LANES; l++) begin
      if (os_q[l].size() != 0 || data_q[l].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drain_queues();
    int waited;
    waited = 0;
    while (!queues_empty() && waited < DRAIN_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (!queues_empty()) begin
      report_problem($sformatf("%s: expected words never came out before the timeout",
                               cur_name));
    end
    // a couple more cycles so stray late words land in this test
    repeat (2) @(posedge clk_i);
  endtask

  task automatic add_entry(input int idx, input string name, input rate_speed_e rate,
                           input int lanes, input logic link, input int lane,
                           input logic [1:0] head, input logic [1:0] tail,
                           input int words, input int exp_os, input int exp_data);
    stim_t s;
    s.rate          = rate;
    s.lanes         = LANE_CNT_W'(lanes);
    s.link          = link;
    s.lane          = 2'(lane);
    s.head_hdr      = head;
    s.tail_hdr      = tail;
    s.words         = 4'(words);
    s.exp_os        = 4'(exp_os);
    s.exp_data      = 4'(exp_data);
    s.start         = $random(seed);
    stim_table[idx] = s;
    test_name[idx]  = name;
  endtask

  task automatic load_table();
    // idx name rate lanes link lane first_hdr later_hdr words os_words data_words
    add_entry(0,  "gen3_os_l0",     GEN3, 4, 1'b1, 0, SYNC_OS,   SYNC_DATA, 8, 8, 0);
    add_entry(1,  "gen4_data_l0",   GEN4, 4, 1'b1, 0, SYNC_DATA, SYNC_OS,   4, 0, 4);
    add_entry(2,  "gen4_data_l1",   GEN4, 4, 1'b1, 1, SYNC_DATA, 2'b00,     4, 0, 4);
    add_entry(3,  "gen4_data_l2",   GEN4, 4, 1'b1, 2, SYNC_DATA, 2'b11,     4, 0, 4);
    add_entry(4,  "gen4_data_l3",   GEN4, 4, 1'b1, 3, SYNC_DATA, SYNC_OS,   4, 0, 4);
    add_entry(5,  "gen5_data_l1",   GEN5, 4, 1'b1, 1, SYNC_DATA, 2'b00,     4, 0, 4);
    add_entry(6,  "gen5_data_l3",   GEN5, 4, 1'b1, 3, SYNC_DATA, SYNC_OS,   4, 0, 4);
    add_entry(7,  "misalign_00",    GEN4, 4, 1'b1, 2, 2'b00,     2'b00,     3, 0, 0);
    add_entry(8,  "misalign_11",    GEN4, 4, 1'b1, 2, 2'b11,     2'b11,     2, 0, 0);
    add_entry(9,  "realign_os",     GEN4, 4, 1'b1, 2, SYNC_OS,   SYNC_DATA, 4, 4, 0);
    add_entry(10, "gen1_any_hdr",   GEN1, 4, 1'b1, 0, SYNC_OS,   2'b11,     5, 0, 5);
    add_entry(11, "gen2_any_hdr",   GEN2, 4, 1'b1, 3, 2'b00,     SYNC_OS,   5, 0, 5);
    add_entry(12, "lanes2_l2_drop", GEN3, 2, 1'b1, 2, SYNC_OS,   SYNC_OS,   8, 0, 0);
    add_entry(13, "lanes2_l3_drop", GEN3, 2, 1'b1, 3, SYNC_DATA, SYNC_DATA, 8, 0, 0);
    add_entry(14, "lanes2_l1_pass", GEN3, 2, 1'b1, 1, SYNC_DATA, SYNC_OS,   8, 0, 8);
    add_entry(15, "link_partial",   GEN4, 4, 1'b1, 1, SYNC_OS,   SYNC_DATA, 2, 2, 0);
    add_entry(16, "link_down",      GEN4, 4, 1'b0, 1, SYNC_OS,   SYNC_OS,   3, 0, 0);
    add_entry(17, "link_fresh",     GEN4, 4, 1'b1, 1, SYNC_DATA, SYNC_OS,   4, 0, 4);
  endtask

  // outputs sampled on the falling edge while stable
  always @(negedge clk_i) begin : output_monitor
    expect_t exp;
    if (rst_i !== 1'b0 || settle_cnt < 2) begin
      if (rst_i === 1'b0) begin
        settle_cnt = settle_cnt + 1;
      end
      if ((os_valid_o | os_last_o | data_valid_o | data_last_o) !== '0) begin
        report_problem("a valid or last output is high during or right after reset");
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (os_valid_o[l] !== 1'b0) begin
          os_seen++;
          if (os_q[l].size() == 0) begin
            report_problem($sformatf("%s: unexpected ordered-set word on lane %0d",
                                     cur_name, l));
          end else begin
            exp = os_q[l].pop_front();
            check_word($sformatf("%s lane %0d os word", cur_name, l), exp.word, os_word_o[l]);
            check_flag($sformatf("%s lane %0d os last", cur_name, l), exp.last, os_last_o[l]);
          end
        end
        if (data_valid_o[l] !== 1'b0) begin
          data_seen++;
          if (data_q[l].size() == 0) begin
            report_problem($sformatf("%s: unexpected data word on lane %0d", cur_name, l));
          end else begin
            exp = data_q[l].pop_front();
            check_word($sformatf("%s lane %0d data word", cur_name, l), exp.word,
                       data_word_o[l]);
            check_flag($sformatf("%s lane %0d data last", cur_name, l), exp.last,
                       data_last_o[l]);
          end
        end
      end
    end
  end

  initial begin : stimulus
    stim_t                cur;
    lane_word_t           w;
    logic [NUM_LANES-1:0] lane_mask;
    clk_i              = 1'b0;
    rst_i              <= 1'b1;
    phy_link_up_i      <= 1'b0;
    curr_data_rate_i   <= GEN1;
    num_active_lanes_i <= LANE_CNT_W'(NUM_LANES);
    data_valid_i       <= '0;
    foreach (data_i[l]) begin
      data_i[l] <= '0;
    end
    seed        = 32'h7380_dc27;
    error_count = 0;
    settle_cnt  = 0;
    os_seen     = 0;
    data_seen   = 0;
    cur_name    = "reset";
    load_table();
    reset_model();

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int t = 0; t < NUM_TESTS; t++) begin
      cur      = stim_table[t];
      cur_name = test_name[t];
      @(posedge clk_i);
      os_seen            = 0;
      data_seen          = 0;
      curr_data_rate_i   <= cur.rate;
      num_active_lanes_i <= cur.lanes;
      phy_link_up_i      <= cur.link;
      // link loss and the 8b/10b rates both leave every lane idle
      if (!cur.link || cur.rate < GEN3) begin
        reset_model();
      end
      repeat (2) @(posedge clk_i);

      lane_mask           = '0;
      lane_mask[cur.lane] = 1'b1;
      for (int i = 0; i < int'(cur.words); i++) begin
        w.data           = cur.start + LANE_DATA_W'(i);
        w.d_k            = cur.start[LANE_K_W-1:0] ^ LANE_K_W'(i);
        w.sync_header    = (i == 0) ? cur.head_hdr : cur.tail_hdr;
        data_i[cur.lane] <= w;
        data_valid_i     <= lane_mask;
        predict_word(cur, w);
        @(posedge clk_i);
      end
      data_valid_i <= '0;

      drain_queues();
      check_count($sformatf("%s os word count", cur_name), int'(cur.exp_os), os_seen);
      check_count($sformatf("%s data word count", cur_name), int'(cur.exp_data), data_seen);
    end

    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim.f
hw/pcie_block_align_pkg.sv
hw/rate_config.sv
hw/lane_block_tracker.sv
hw/block_alignment.sv
testbench/block_alignment_sva.sv
testbench/block_alignment_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module block_alignment_tb \
  -f sim.f \
  -o block_alignment_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/block_alignment_sim 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Regression passed" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
